// ==== source/gat_pkg.sv ====
package gat_pkg;

  ////////////////////////////////////////
  // datapath types
  ////////////////////////////////////////

  typedef logic signed [15:0] feat_t;
  typedef logic        [3:0]  col_t;
  typedef logic signed [7:0]  wgt_t;
  typedef logic signed [31:0] acc_t;
  typedef logic signed [15:0] score_t;
  typedef logic signed [19:0] sum_t;
  typedef logic        [31:0] cnt_t;

  ////////////////////////////////////////
  // pipeline geometry
  ////////////////////////////////////////

  localparam int NUM_COLS    = 16;
  localparam int WIN_LEN     = 4;
  localparam int GROUP_LEN   = 4;
  localparam int LRELU_SHIFT = 3;

  // score saturation limits, held at accumulator width for the compare
  localparam acc_t SCORE_MAX = 32'sd32767;
  localparam acc_t SCORE_MIN = -32'sd32768;

  // rows whose sparse result the debugger keeps
  localparam cnt_t DBG_ROW_A = 32'd10;
  localparam cnt_t DBG_ROW_B = 32'd20;

  ////////////////////////////////////////
  // sparse stage FSM
  ////////////////////////////////////////

  typedef enum logic {
    IDLE,
    ACCUM
  } spmm_state_e;

endpackage

// ==== source/spmm_unit.sv ====
`timescale 1ns/1ps

module spmm_unit (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            entry_vld_i,
  input  gat_pkg::feat_t  entry_val_i,
  input  gat_pkg::col_t   entry_col_i,
  input  logic            row_last_i,
  input  logic            wgt_we_i,
  input  gat_pkg::col_t   wgt_addr_i,
  input  gat_pkg::wgt_t   wgt_data_i,
  output logic            spmm_vld_o,
  output logic            spmm_rdy_o,
  output gat_pkg::acc_t   spmm_data_o
);

  gat_pkg::wgt_t        weights [gat_pkg::NUM_COLS];
  gat_pkg::spmm_state_e state;
  gat_pkg::acc_t        acc;
  gat_pkg::acc_t        prod;
  gat_pkg::acc_t        acc_sum;

  // one feature times the weight of its column
  assign prod    = gat_pkg::acc_t'(entry_val_i) * gat_pkg::acc_t'(weights[entry_col_i]);
  assign acc_sum = acc + prod;

  ////////////////////////////////////////
  // weight table
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < gat_pkg::NUM_COLS; i++) begin
        weights[i] <= '0;
      end
    end else if (wgt_we_i) begin
      weights[wgt_addr_i] <= wgt_data_i;
    end
  end

  ////////////////////////////////////////
  // row accumulation
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= gat_pkg::IDLE;
      acc        <= '0;
      spmm_vld_o <= 1'b0;
    end else begin
      spmm_vld_o <= 1'b0;
      if (entry_vld_i) begin
        if (row_last_i) begin
          acc        <= '0;
          spmm_vld_o <= 1'b1;
          state      <= gat_pkg::IDLE;
        end else begin
          acc   <= acc_sum;
          state <= gat_pkg::ACCUM;
        end
      end
    end
  end

  // result register, only meaningful with the valid pulse
  always_ff @(posedge clk) begin
    if (entry_vld_i && row_last_i) begin
      spmm_data_o <= acc_sum;
    end
  end

  // no partial row held
  assign spmm_rdy_o = (state == gat_pkg::IDLE);

endmodule

// ==== source/dmvm_unit.sv ====
`timescale 1ns/1ps

module dmvm_unit (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 spmm_vld_i,
  input  gat_pkg::acc_t                        spmm_data_i,
  input  logic                                 att_we_i,
  input  logic [$clog2(gat_pkg::WIN_LEN)-1:0]  att_addr_i,
  input  gat_pkg::wgt_t                        att_data_i,
  output logic                                 dmvm_vld_o,
  output logic                                 dmvm_rdy_o,
  output gat_pkg::acc_t                        dmvm_data_o
);

  gat_pkg::acc_t win      [gat_pkg::WIN_LEN];
  gat_pkg::acc_t win_next [gat_pkg::WIN_LEN];
  gat_pkg::wgt_t att      [gat_pkg::WIN_LEN];
  gat_pkg::acc_t dot;

  // window after the incoming result is shifted in at position 0
  always_comb begin
    win_next[0] = spmm_data_i;
    for (int i = 1; i < gat_pkg::WIN_LEN; i++) begin
      win_next[i] = win[i-1];
    end
    dot = '0;
    for (int i = 0; i < gat_pkg::WIN_LEN; i++) begin
      dot = dot + win_next[i] * gat_pkg::acc_t'(att[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < gat_pkg::WIN_LEN; i++) begin
        win[i] <= '0;
        att[i] <= '0;
      end
      dmvm_vld_o <= 1'b0;
    end else begin
      dmvm_vld_o <= spmm_vld_i;
      if (att_we_i) begin
        att[att_addr_i] <= att_data_i;
      end
      if (spmm_vld_i) begin
        win <= win_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (spmm_vld_i) begin
      dmvm_data_o <= dot;
    end
  end

  // busy only while the result is on the output
  assign dmvm_rdy_o = ~dmvm_vld_o;

endmodule

// ==== source/score_unit.sv ====
`timescale 1ns/1ps

module score_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             dmvm_vld_i,
  input  gat_pkg::acc_t    dmvm_data_i,
  output logic             sm_vld_o,
  output logic             sm_rdy_o,
  output gat_pkg::score_t  sm_data_o
);

  gat_pkg::acc_t   relu;
  gat_pkg::score_t clamped;

  // leaky relu: negative slope is a plain arithmetic shift
  always_comb begin
    relu = dmvm_data_i;
    if (dmvm_data_i[$bits(gat_pkg::acc_t)-1]) begin
      relu = dmvm_data_i >>> gat_pkg::LRELU_SHIFT;
    end
    if (relu > gat_pkg::SCORE_MAX) begin
      clamped = gat_pkg::score_t'(gat_pkg::SCORE_MAX);
    end else if (relu < gat_pkg::SCORE_MIN) begin
      clamped = gat_pkg::score_t'(gat_pkg::SCORE_MIN);
    end else begin
      clamped = gat_pkg::score_t'(relu);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_vld_o <= 1'b0;
    end else begin
      sm_vld_o <= dmvm_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (dmvm_vld_i) begin
      sm_data_o <= clamped;
    end
  end

  assign sm_rdy_o = ~sm_vld_o;

endmodule

// ==== source/aggr_unit.sv ====
`timescale 1ns/1ps

module aggr_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             sm_vld_i,
  input  gat_pkg::score_t  sm_data_i,
  output logic             aggr_vld_o,
  output logic             aggr_rdy_o,
  output gat_pkg::sum_t    aggr_sum_o
);

  logic [$clog2(gat_pkg::GROUP_LEN)-1:0] cnt;
  gat_pkg::sum_t                         acc;
  gat_pkg::sum_t                         acc_sum;
  logic                                  group_done;

  assign acc_sum    = acc + gat_pkg::sum_t'(sm_data_i);
  assign group_done = sm_vld_i && (cnt == gat_pkg::GROUP_LEN - 1);

  ////////////////////////////////////////
  // group accumulation
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt        <= '0;
      acc        <= '0;
      aggr_vld_o <= 1'b0;
    end else begin
      aggr_vld_o <= group_done;
      if (group_done) begin
        cnt <= '0;
        acc <= '0;
      end else if (sm_vld_i) begin
        cnt <= cnt + 1'b1;
        acc <= acc_sum;
      end
    end
  end

  // total includes the score that closes the group
  always_ff @(posedge clk) begin
    if (group_done) begin
      aggr_sum_o <= acc_sum;
    end
  end

  assign aggr_rdy_o = (cnt == '0);

endmodule

// ==== source/debugger.sv ====
`timescale 1ns/1ps

module debugger (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           spmm_vld_i,
  input  logic           spmm_rdy_i,
  input  logic           dmvm_vld_i,
  input  logic           dmvm_rdy_i,
  input  logic           sm_vld_i,
  input  logic           sm_rdy_i,
  input  logic           aggr_vld_i,
  input  logic           aggr_rdy_i,
  input  gat_pkg::acc_t  spmm_data_i,
  output logic [7:0]     debug_status_o,
  output gat_pkg::cnt_t  debug_count_o,
  output gat_pkg::acc_t  debug_cap_a_o,
  output gat_pkg::acc_t  debug_cap_b_o
);

  logic [7:0]    observed;
  logic [7:0]    flags;
  gat_pkg::cnt_t sm_cnt;
  gat_pkg::cnt_t row_cnt;

  // msb first: spmm, dmvm, sm, aggr, each as vld then rdy
  assign observed = {spmm_vld_i, spmm_rdy_i,
                     dmvm_vld_i, dmvm_rdy_i,
                     sm_vld_i,   sm_rdy_i,
                     aggr_vld_i, aggr_rdy_i};

  ////////////////////////////////////////
  // sticky stage flags
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else begin
      flags <= flags | observed;
    end
  end

  ////////////////////////////////////////
  // event counters and row captures
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_cnt        <= '0;
      row_cnt       <= '0;
      debug_cap_a_o <= '0;
      debug_cap_b_o <= '0;
    end else begin
      if (sm_vld_i) begin
        sm_cnt <= sm_cnt + 1'b1;
      end
      if (spmm_vld_i) begin
        // row_cnt is the zero-based number of the row finishing now
        row_cnt <= row_cnt + 1'b1;
        if (row_cnt == gat_pkg::DBG_ROW_A) begin
          debug_cap_a_o <= spmm_data_i;
        end
        if (row_cnt == gat_pkg::DBG_ROW_B) begin
          debug_cap_b_o <= spmm_data_i;
        end
      end
    end
  end

  assign debug_status_o = flags;
  assign debug_count_o  = sm_cnt;

endmodule

// ==== source/gat_core.sv ====
`timescale 1ns/1ps

module gat_core (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // sparse entry stream
  input  logic                                 entry_vld_i,
  input  gat_pkg::feat_t                       entry_val_i,
  input  gat_pkg::col_t                        entry_col_i,
  input  logic                                 row_last_i,
  // weight table write
  input  logic                                 wgt_we_i,
  input  gat_pkg::col_t                        wgt_addr_i,
  input  gat_pkg::wgt_t                        wgt_data_i,
  // attention vector write
  input  logic                                 att_we_i,
  input  logic [$clog2(gat_pkg::WIN_LEN)-1:0]  att_addr_i,
  input  gat_pkg::wgt_t                        att_data_i,
  // group totals
  output logic                                 aggr_vld_o,
  output gat_pkg::sum_t                        aggr_sum_o,
  // debug monitor
  output logic [7:0]                           debug_status_o,
  output gat_pkg::cnt_t                        debug_count_o,
  output gat_pkg::acc_t                        debug_cap_a_o,
  output gat_pkg::acc_t                        debug_cap_b_o
);

  logic            spmm_vld;
  logic            spmm_rdy;
  gat_pkg::acc_t   spmm_data;
  logic            dmvm_vld;
  logic            dmvm_rdy;
  gat_pkg::acc_t   dmvm_data;
  logic            sm_vld;
  logic            sm_rdy;
  gat_pkg::score_t sm_data;
  logic            aggr_rdy;

  ////////////////////////////////////////
  // stage chain
  ////////////////////////////////////////

  spmm_unit u_spmm (
    .clk         (clk),
    .rst_n       (rst_n),
    .entry_vld_i (entry_vld_i),
    .entry_val_i (entry_val_i),
    .entry_col_i (entry_col_i),
    .row_last_i  (row_last_i),
    .wgt_we_i    (wgt_we_i),
    .wgt_addr_i  (wgt_addr_i),
    .wgt_data_i  (wgt_data_i),
    .spmm_vld_o  (spmm_vld),
    .spmm_rdy_o  (spmm_rdy),
    .spmm_data_o (spmm_data)
  );

  dmvm_unit u_dmvm (
    .clk         (clk),
    .rst_n       (rst_n),
    .spmm_vld_i  (spmm_vld),
    .spmm_data_i (spmm_data),
    .att_we_i    (att_we_i),
    .att_addr_i  (att_addr_i),
    .att_data_i  (att_data_i),
    .dmvm_vld_o  (dmvm_vld),
    .dmvm_rdy_o  (dmvm_rdy),
    .dmvm_data_o (dmvm_data)
  );

  score_unit u_score (
    .clk         (clk),
    .rst_n       (rst_n),
    .dmvm_vld_i  (dmvm_vld),
    .dmvm_data_i (dmvm_data),
    .sm_vld_o    (sm_vld),
    .sm_rdy_o    (sm_rdy),
    .sm_data_o   (sm_data)
  );

  aggr_unit u_aggr (
    .clk        (clk),
    .rst_n      (rst_n),
    .sm_vld_i   (sm_vld),
    .sm_data_i  (sm_data),
    .aggr_vld_o (aggr_vld_o),
    .aggr_rdy_o (aggr_rdy),
    .aggr_sum_o (aggr_sum_o)
  );

  // listens to every stage, drives nothing back
  debugger u_debugger (
    .clk            (clk),
    .rst_n          (rst_n),
    .spmm_vld_i     (spmm_vld),
    .spmm_rdy_i     (spmm_rdy),
    .dmvm_vld_i     (dmvm_vld),
    .dmvm_rdy_i     (dmvm_rdy),
    .sm_vld_i       (sm_vld),
    .sm_rdy_i       (sm_rdy),
    .aggr_vld_i     (aggr_vld_o),
    .aggr_rdy_i     (aggr_rdy),
    .spmm_data_i    (spmm_data),
    .debug_status_o (debug_status_o),
    .debug_count_o  (debug_count_o),
    .debug_cap_a_o  (debug_cap_a_o),
    .debug_cap_b_o  (debug_cap_b_o)
  );

endmodule

// ==== sim/gat_core_asserts.sv ====
`timescale 1ns/1ps

module gat_core_asserts (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  entry_vld_i,
  input  logic  row_last_i,
  input  logic  spmm_vld_i,
  input  logic  spmm_rdy_i,
  input  logic  dmvm_vld_i,
  input  logic  sm_vld_i,
  input  logic  aggr_vld_i
);

  logic [1:0] sm_seen;
  logic       group_end;

  // score pulses seen in the current group
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_seen <= '0;
    end else if (sm_vld_i) begin
      sm_seen <= sm_seen + 1'b1;
    end
  end

  assign group_end = sm_vld_i && (sm_seen == 2'd3);

  ////////////////////////////////////////
  // one-cycle valid pulses
  ////////////////////////////////////////

  spmm_pulse: assert property (@(posedge clk) disable iff (!rst_n) spmm_vld_i |=> !spmm_vld_i)
    else $error("spmm valid high for two cycles");
  dmvm_pulse: assert property (@(posedge clk) disable iff (!rst_n) dmvm_vld_i |=> !dmvm_vld_i)
    else $error("dmvm valid high for two cycles");
  sm_pulse: assert property (@(posedge clk) disable iff (!rst_n) sm_vld_i |=> !sm_vld_i)
    else $error("sm valid high for two cycles");
  aggr_pulse: assert property (@(posedge clk) disable iff (!rst_n) aggr_vld_i |=> !aggr_vld_i)
    else $error("aggr valid high for two cycles");

  ////////////////////////////////////////
  // row in progress and group output
  ////////////////////////////////////////

  row_busy: assert property (@(posedge clk) disable iff (!rst_n)
    entry_vld_i && !row_last_i |=> !spmm_rdy_i)
    else $error("spmm ready high after a non-final entry");
  row_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !spmm_rdy_i && !(entry_vld_i && row_last_i) |=> !spmm_rdy_i)
    else $error("spmm ready rose before the last entry of the row");
  group_out: assert property (@(posedge clk) disable iff (!rst_n) group_end |=> aggr_vld_i)
    else $error("no aggr valid after the fourth score");
  group_only: assert property (@(posedge clk) disable iff (!rst_n) aggr_vld_i |-> $past(group_end))
    else $error("aggr valid without a completed group");

endmodule

bind gat_core gat_core_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .entry_vld_i (entry_vld_i),
  .row_last_i  (row_last_i),
  .spmm_vld_i  (spmm_vld),
  .spmm_rdy_i  (spmm_rdy),
  .dmvm_vld_i  (dmvm_vld),
  .sm_vld_i    (sm_vld),
  .aggr_vld_i  (aggr_vld_o)
);

// ==== sim/tb_gat_core.sv ====
`timescale 1ns/1ps

module tb_gat_core;

  localparam int MAX_CYCLES = 2000;

  logic           clk;
  logic           rst_n;
  logic           entry_vld_i;
  gat_pkg::feat_t entry_val_i;
  gat_pkg::col_t  entry_col_i;
  logic           row_last_i;
  logic           wgt_we_i;
  gat_pkg::col_t  wgt_addr_i;
  gat_pkg::wgt_t  wgt_data_i;
  logic           att_we_i;
  logic [1:0]     att_addr_i;
  gat_pkg::wgt_t  att_data_i;
  logic           aggr_vld_o;
  gat_pkg::sum_t  aggr_sum_o;
  logic [7:0]     debug_status_o;
  gat_pkg::cnt_t  debug_count_o;
  gat_pkg::acc_t  debug_cap_a_o;
  gat_pkg::acc_t  debug_cap_b_o;

  int seed = 32'h8fc64cbf;
  int errors = 0;
  int checks = 0;
  int cycle_cnt = 0;

  // reference model state
  int            wgt_m [gat_pkg::NUM_COLS];
  int            att_m [gat_pkg::WIN_LEN];
  int            win_m [gat_pkg::WIN_LEN];
  int            row_acc = 0;
  int            grp_acc = 0;
  int            grp_cnt = 0;
  int            rows_m [$];
  gat_pkg::sum_t exp_q [$];
  gat_pkg::sum_t got_q [$];

  gat_core u_gat_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .entry_vld_i    (entry_vld_i),
    .entry_val_i    (entry_val_i),
    .entry_col_i    (entry_col_i),
    .row_last_i     (row_last_i),
    .wgt_we_i       (wgt_we_i),
    .wgt_addr_i     (wgt_addr_i),
    .wgt_data_i     (wgt_data_i),
    .att_we_i       (att_we_i),
    .att_addr_i     (att_addr_i),
    .att_data_i     (att_data_i),
    .aggr_vld_o     (aggr_vld_o),
    .aggr_sum_o     (aggr_sum_o),
    .debug_status_o (debug_status_o),
    .debug_count_o  (debug_count_o),
    .debug_cap_a_o  (debug_cap_a_o),
    .debug_cap_b_o  (debug_cap_b_o)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles without finishing the tests", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // group totals as the DUT emits them
  always @(negedge clk) begin
    if (rst_n && aggr_vld_o) begin
      got_q.push_back(aggr_sum_o);
    end
  end

  ////////////////////////////////////////
  // checks and reference model
  ////////////////////////////////////////

  task automatic expect_eq(string what, longint got, longint exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic int leaky_clamp(int d);
    int r;
    r = d;
    if (d < 0) begin
      r = d >>> 3;
    end
    if (r > 32767) begin
      r = 32767;
    end else if (r < -32768) begin
      r = -32768;
    end
    return r;
  endfunction

  // one finished row through window, dot product, score and grouping
  task automatic close_row(int s);
    int dot;
    rows_m.push_back(s);
    for (int i = gat_pkg::WIN_LEN - 1; i > 0; i--) begin
      win_m[i] = win_m[i-1];
    end
    win_m[0] = s;
    dot = 0;
    for (int i = 0; i < gat_pkg::WIN_LEN; i++) begin
      dot = dot + win_m[i] * att_m[i];
    end
    grp_acc = grp_acc + leaky_clamp(dot);
    grp_cnt++;
    if (grp_cnt == 4) begin
      exp_q.push_back(gat_pkg::sum_t'(grp_acc));
      grp_acc = 0;
      grp_cnt = 0;
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic write_weight(gat_pkg::col_t addr, gat_pkg::wgt_t data);
    wgt_we_i   = 1'b1;
    wgt_addr_i = addr;
    wgt_data_i = data;
    wgt_m[addr] = int'(data);
    @(negedge clk);
    wgt_we_i = 1'b0;
  endtask

  task automatic write_att(logic [1:0] addr, gat_pkg::wgt_t data);
    att_we_i   = 1'b1;
    att_addr_i = addr;
    att_data_i = data;
    att_m[addr] = int'(data);
    @(negedge clk);
    att_we_i = 1'b0;
  endtask

  task automatic send_entry(gat_pkg::feat_t val, gat_pkg::col_t col, bit last);
    entry_vld_i = 1'b1;
    entry_val_i = val;
    entry_col_i = col;
    row_last_i  = last;
    row_acc = row_acc + int'(val) * wgt_m[col];
    if (last) begin
      close_row(row_acc);
      row_acc = 0;
    end
    @(negedge clk);
    entry_vld_i = 1'b0;
    row_last_i  = 1'b0;
    // idle cycle between rows keeps every stage valid a single-cycle pulse
    if (last) begin
      @(negedge clk);
    end
  endtask

  task automatic send_random_row();
    int             len;
    gat_pkg::feat_t val;
    gat_pkg::col_t  col;
    len = 1 + ($unsigned($random(seed)) % 6);
    for (int i = 0; i < len; i++) begin
      val = gat_pkg::feat_t'($random(seed));
      col = gat_pkg::col_t'($random(seed));
      send_entry(val, col, i == len - 1);
    end
  endtask

  task automatic check_groups(string name);
    int waited;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < 40) begin
      @(negedge clk);
      waited++;
    end
    // four-cycle latency, so any surplus total shows up in this window
    repeat (8) @(negedge clk);
    expect_eq({name, " number of group totals"}, got_q.size(), exp_q.size());
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      expect_eq({name, " group sum"}, got_q.pop_front(), exp_q.pop_front());
    end
    got_q.delete();
    exp_q.delete();
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset();
    expect_eq("aggr_vld_o after reset", aggr_vld_o, 0);
    expect_eq("debug_count_o after reset", debug_count_o, 0);
    expect_eq("debug_cap_a_o after reset", debug_cap_a_o, 0);
    expect_eq("debug_cap_b_o after reset", debug_cap_b_o, 0);
    @(negedge clk);
    expect_eq("debug_status_o one cycle after reset", debug_status_o, 8'h55);
  endtask

  task automatic test_random_group();
    for (int c = 0; c < gat_pkg::NUM_COLS; c++) begin
      write_weight(gat_pkg::col_t'(c), gat_pkg::wgt_t'($random(seed)));
    end
    for (int a = 0; a < gat_pkg::WIN_LEN; a++) begin
      write_att(2'(a), gat_pkg::wgt_t'($random(seed)));
    end
    repeat (4) send_random_row();
    check_groups("random group");
  endtask

  // only att[0] set, so each score follows its own row directly
  task automatic test_saturation();
    write_weight(4'd0, 8'sd100);
    write_weight(4'd1, -8'sd100);
    write_weight(4'd2, 8'sd1);
    write_att(2'd0, 8'sd1);
    write_att(2'd1, 8'sd0);
    write_att(2'd2, 8'sd0);
    write_att(2'd3, 8'sd0);
    send_entry(16'sd32767, 4'd0, 1'b1);
    send_entry(16'sd32767, 4'd1, 1'b1);
    send_entry(16'sd2000, 4'd1, 1'b1);
    send_entry(16'sd300, 4'd0, 1'b0);
    send_entry(16'sd5, 4'd2, 1'b1);
    send_entry(-16'sd7, 4'd2, 1'b1);
    send_entry(16'sd32767, 4'd0, 1'b0);
    send_entry(16'sd32767, 4'd0, 1'b1);
    send_entry(-16'sd32768, 4'd0, 1'b1);
    send_entry(16'sd1000, 4'd1, 1'b0);
    send_entry(16'sd999, 4'd0, 1'b1);
    check_groups("saturation");
  endtask

  // ten rows leave two scores waiting in an open group
  task automatic test_two_groups();
    for (int a = 0; a < gat_pkg::WIN_LEN; a++) begin
      write_att(2'(a), gat_pkg::wgt_t'($random(seed)));
    end
    repeat (10) send_random_row();
    check_groups("eight rows");
  endtask

  task automatic test_debugger();
    repeat (2) send_random_row();
    check_groups("closing group");
    expect_eq("debug_count_o", debug_count_o, rows_m.size());
    expect_eq("debug_status_o", debug_status_o, 8'hff);
    expect_eq("debug_cap_a_o", debug_cap_a_o, rows_m[gat_pkg::DBG_ROW_A]);
    expect_eq("debug_cap_b_o", debug_cap_b_o, rows_m[gat_pkg::DBG_ROW_B]);
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    entry_vld_i = 1'b0;
    entry_val_i = '0;
    entry_col_i = '0;
    row_last_i  = 1'b0;
    wgt_we_i    = 1'b0;
    wgt_addr_i  = '0;
    wgt_data_i  = '0;
    att_we_i    = 1'b0;
    att_addr_i  = '0;
    att_data_i  = '0;
    wgt_m = '{default: 0};
    att_m = '{default: 0};
    win_m = '{default: 0};
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_random_group();
    test_saturation();
    test_two_groups();
    test_debugger();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== gat_core.f ====
source/gat_pkg.sv
source/spmm_unit.sv
source/dmvm_unit.sv
source/score_unit.sv
source/aggr_unit.sv
source/debugger.sv
source/gat_core.sv
sim/gat_core_asserts.sv
sim/tb_gat_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build tb_gat_core with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_gat_core \
  -f gat_core.f -o tb_gat_core || { echo "build failed"; exit 1; }
./obj_dir/tb_gat_core > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "result: fail"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "result: no pass line in log"; exit 1; }
echo "result: pass"
